// File: hdl/cache_req_pkg.sv
package cache_req_pkg;

  // ----------------------------------------------------------------------
  // Address and requestor sizing
  // ----------------------------------------------------------------------

  // Base, offset and cache line address all share this width
  localparam int addr_width = 32;

  // Requestor ports feeding the round-robin arbiter
  localparam int num_requestors = 2;

  // ----------------------------------------------------------------------
  // Request FIFO sizing
  // ----------------------------------------------------------------------

  // Entries in the request FIFO
  localparam int fifo_depth = 8;
  // Pointer wraps naturally at a power-of-two depth
  localparam int fifo_ptr_width = $clog2(fifo_depth);
  // Occupancy needs one extra code for the full state
  localparam int fifo_count_width = $clog2(fifo_depth + 1);

  // ----------------------------------------------------------------------
  // Outstanding transaction credits
  // ----------------------------------------------------------------------

  // Cache requests allowed in flight without a response
  localparam int outstanding_max = 4;
  // Holds 0 up to outstanding_max
  localparam int credit_width = 3;

  // ----------------------------------------------------------------------
  // Request word
  // ----------------------------------------------------------------------

  // Line address plus the number of the requestor that asked for it
  typedef struct packed {
    logic [addr_width-1:0] addr;
    logic                  src;
  } cache_req_t;

endpackage

// File: hdl/cache_req_if.sv
interface cache_req_if;
  import cache_req_pkg::*;

  // ----------------------------------------------------------------------
  // One cache request link
  // ----------------------------------------------------------------------

  // Source holds valid and req stable until ready
  logic       valid;
  // Sink may raise ready regardless of valid
  logic       ready;
  // Line address and requestor number
  cache_req_t req;

  // Transfer on any rising edge with valid and ready both high

  // Producer side
  modport source (
    output valid,
    output req,
    input  ready
  );

  // Consumer side
  modport sink (
    input  valid,
    input  req,
    output ready
  );

endinterface

// File: hdl/request_arbiter.sv
module request_arbiter (
  input  logic                                 ap_clk,
  input  logic                                 control_areset,
  input  logic                                 req_a_valid,
  output logic                                 req_a_ready,
  input  logic [cache_req_pkg::addr_width-1:0] req_a_base,
  input  logic [cache_req_pkg::addr_width-1:0] req_a_offset,
  input  logic                                 req_b_valid,
  output logic                                 req_b_ready,
  input  logic [cache_req_pkg::addr_width-1:0] req_b_base,
  input  logic [cache_req_pkg::addr_width-1:0] req_b_offset,
  cache_req_if.source                          req_out
);
  import cache_req_pkg::*;

  // ----------------------------------------------------------------------
  // Arbitration signals
  // ----------------------------------------------------------------------

  // Bit 0 is requestor a, bit 1 is requestor b
  logic [num_requestors-1:0] req_valid;
  logic [num_requestors-1:0] grant;

  // Low for the first cycle out of reset
  logic ready_en;
  // Set when requestor b has priority on a tie
  logic rr_ptr;
  logic pick_b;
  logic stage_free;
  logic accept;

  // Selected operands and their sum
  logic [addr_width-1:0] sel_base;
  logic [addr_width-1:0] sel_offset;
  logic [addr_width-1:0] line_addr;

  // Output stage toward the FIFO
  logic       out_valid;
  cache_req_t out_req;

  // ----------------------------------------------------------------------
  // Round-robin grant
  // ----------------------------------------------------------------------

  assign req_valid = {req_b_valid, req_a_valid};

  // b wins when alone, or on a tie when it was not served last
  assign pick_b = req_valid[1] & (~req_valid[0] | rr_ptr);

  // Stage empty or draining into the FIFO this cycle
  assign stage_free = ready_en & (~out_valid | req_out.ready);

  // Only the picked requestor sees ready
  assign grant[0] = stage_free & ~pick_b;
  assign grant[1] = stage_free & pick_b;

  assign req_a_ready = grant[0];
  assign req_b_ready = grant[1];

  // Handshake on the granted port
  assign accept = |(grant & req_valid);

  // ----------------------------------------------------------------------
  // Line address formation
  // ----------------------------------------------------------------------

  assign sel_base   = pick_b ? req_b_base : req_a_base;
  assign sel_offset = pick_b ? req_b_offset : req_a_offset;
  // Wraps at addr_width like the cache address space
  assign line_addr  = sel_base + sel_offset;

  // Control state
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      ready_en  <= 1'b0;
      rr_ptr    <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      ready_en <= 1'b1;
      if (accept) begin
        out_valid <= 1'b1;
        // Other requestor goes first on the next tie
        rr_ptr    <= ~pick_b;
      end else if (req_out.ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  // Payload only loads on accept, held otherwise
  always_ff @(posedge ap_clk) begin
    if (accept) begin
      out_req.addr <= line_addr;
      out_req.src  <= pick_b;
    end
  end

  assign req_out.valid = out_valid;
  assign req_out.req   = out_req;

endmodule

// File: hdl/cache_req_fifo.sv
module cache_req_fifo (
  input  logic      ap_clk,
  input  logic      control_areset,
  cache_req_if.sink wr,
  cache_req_if.source rd
);
  import cache_req_pkg::*;

  // ----------------------------------------------------------------------
  // Storage and bookkeeping
  // ----------------------------------------------------------------------

  // Circular buffer
  cache_req_t mem [0:fifo_depth-1];

  logic [fifo_ptr_width-1:0]   wr_ptr;
  logic [fifo_ptr_width-1:0]   rd_ptr;
  // Entries currently held
  logic [fifo_count_width-1:0] count;

  logic do_wr;
  logic do_rd;

  // ----------------------------------------------------------------------
  // Handshakes
  // ----------------------------------------------------------------------

  // Refuse writes once all entries are taken
  assign wr.ready = (count != fifo_count_width'(fifo_depth));

  // Head entry exposed as soon as the count is nonzero
  assign rd.valid = (count != '0);
  assign rd.req   = mem[rd_ptr];

  assign do_wr = wr.valid & wr.ready;
  assign do_rd = rd.valid & rd.ready;

  // Write port
  always_ff @(posedge ap_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr.req;
    end
  end

  // ----------------------------------------------------------------------
  // Pointers and occupancy
  // ----------------------------------------------------------------------

  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Power-of-two depth, pointers wrap on overflow
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous read and write leaves count alone
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: hdl/cache_req_issuer.sv
module cache_req_issuer (
  input  logic                                 ap_clk,
  input  logic                                 control_areset,
  cache_req_if.sink                            req_in,
  output logic                                 cache_req_valid,
  input  logic                                 cache_req_ready,
  output logic [cache_req_pkg::addr_width-1:0] cache_req_addr,
  output logic                                 cache_req_src,
  input  logic                                 cache_resp_valid
);
  import cache_req_pkg::*;

  // ----------------------------------------------------------------------
  // Credit and output stage state
  // ----------------------------------------------------------------------

  // Free slots for outstanding cache transactions
  logic [credit_width-1:0] credits;
  logic                    has_credit;
  logic                    at_max;

  // Output register toward the cache
  logic       out_valid;
  cache_req_t out_req;
  logic       out_free;
  logic       take;

  // ----------------------------------------------------------------------
  // Take from the FIFO
  // ----------------------------------------------------------------------

  assign has_credit = (credits != '0);
  assign at_max     = (credits == credit_width'(outstanding_max));

  // Register empty or handed to the cache this cycle
  assign out_free = ~out_valid | cache_req_ready;

  assign req_in.ready = out_free & has_credit;
  assign take         = req_in.valid & req_in.ready;

  // Credit counter
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      credits <= credit_width'(outstanding_max);
    end else begin
      case ({take, cache_resp_valid})
        // Spend one on issue
        2'b10: credits <= credits - 1'b1;
        // Return one, never past the ceiling
        2'b01: begin
          if (!at_max) begin
            credits <= credits + 1'b1;
          end
        end
        // Both or neither cancel out
        default: credits <= credits;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // Output register
  // ----------------------------------------------------------------------

  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      out_valid <= 1'b0;
    end else begin
      if (take) begin
        out_valid <= 1'b1;
      end else if (cache_req_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  // Held stable while the cache stalls
  always_ff @(posedge ap_clk) begin
    if (take) begin
      out_req <= req_in.req;
    end
  end

  assign cache_req_valid = out_valid;
  assign cache_req_addr  = out_req.addr;
  assign cache_req_src   = out_req.src;

endmodule

// File: hdl/cache_request_frontend.sv
module cache_request_frontend (
  input  logic                                 ap_clk,
  input  logic                                 control_areset,

  // Requestor a
  input  logic                                 req_a_valid,
  output logic                                 req_a_ready,
  input  logic [cache_req_pkg::addr_width-1:0] req_a_base,
  input  logic [cache_req_pkg::addr_width-1:0] req_a_offset,

  // Requestor b
  input  logic                                 req_b_valid,
  output logic                                 req_b_ready,
  input  logic [cache_req_pkg::addr_width-1:0] req_b_base,
  input  logic [cache_req_pkg::addr_width-1:0] req_b_offset,

  // Cache request out
  output logic                                 cache_req_valid,
  input  logic                                 cache_req_ready,
  output logic [cache_req_pkg::addr_width-1:0] cache_req_addr,
  output logic                                 cache_req_src,

  // One pulse per completed cache transaction
  input  logic                                 cache_resp_valid
);

  // ----------------------------------------------------------------------
  // Internal links
  // ----------------------------------------------------------------------

  // Arbiter stage into the queue
  cache_req_if arb_to_fifo ();
  // Queue head into the issuer
  cache_req_if fifo_to_issuer ();

  // ----------------------------------------------------------------------
  // Arbiter, queue, issuer
  // ----------------------------------------------------------------------

  request_arbiter u_request_arbiter (
    .ap_clk         (ap_clk),
    .control_areset (control_areset),
    .req_a_valid    (req_a_valid),
    .req_a_ready    (req_a_ready),
    .req_a_base     (req_a_base),
    .req_a_offset   (req_a_offset),
    .req_b_valid    (req_b_valid),
    .req_b_ready    (req_b_ready),
    .req_b_base     (req_b_base),
    .req_b_offset   (req_b_offset),
    .req_out        (arb_to_fifo)
  );

  // Eight entries absorb cache back-pressure
  cache_req_fifo u_cache_req_fifo (
    .ap_clk         (ap_clk),
    .control_areset (control_areset),
    .wr             (arb_to_fifo),
    .rd             (fifo_to_issuer)
  );

  // Credit-limited issue to the cache
  cache_req_issuer u_cache_req_issuer (
    .ap_clk           (ap_clk),
    .control_areset   (control_areset),
    .req_in           (fifo_to_issuer),
    .cache_req_valid  (cache_req_valid),
    .cache_req_ready  (cache_req_ready),
    .cache_req_addr   (cache_req_addr),
    .cache_req_src    (cache_req_src),
    .cache_resp_valid (cache_resp_valid)
  );

endmodule

// File: dv/cache_request_frontend_tb.sv
module cache_request_frontend_tb;
  import cache_req_pkg::*;

  // ----------------------------------------------------------------------
  // DUT signals
  // ----------------------------------------------------------------------

  logic                  ap_clk;
  logic                  control_areset;
  logic                  req_a_valid;
  logic                  req_a_ready;
  logic [addr_width-1:0] req_a_base;
  logic [addr_width-1:0] req_a_offset;
  logic                  req_b_valid;
  logic                  req_b_ready;
  logic [addr_width-1:0] req_b_base;
  logic [addr_width-1:0] req_b_offset;
  logic                  cache_req_valid;
  logic                  cache_req_ready;
  logic [addr_width-1:0] cache_req_addr;
  logic                  cache_req_src;
  logic                  cache_resp_valid;

  // Entries still to offer, per requestor
  logic [addr_width-1:0] a_base_q[$];
  logic [addr_width-1:0] a_off_q[$];
  logic [addr_width-1:0] a_addr_q[$];
  logic [addr_width-1:0] b_base_q[$];
  logic [addr_width-1:0] b_off_q[$];
  logic [addr_width-1:0] b_addr_q[$];
  // Accepted but not yet seen at the cache port
  cache_req_t exp_a[$];
  cache_req_t exp_b[$];

  logic [31:0] seed;

  cache_request_frontend u_dut (
    .ap_clk           (ap_clk),
    .control_areset   (control_areset),
    .req_a_valid      (req_a_valid),
    .req_a_ready      (req_a_ready),
    .req_a_base       (req_a_base),
    .req_a_offset     (req_a_offset),
    .req_b_valid      (req_b_valid),
    .req_b_ready      (req_b_ready),
    .req_b_base       (req_b_base),
    .req_b_offset     (req_b_offset),
    .cache_req_valid  (cache_req_valid),
    .cache_req_ready  (cache_req_ready),
    .cache_req_addr   (cache_req_addr),
    .cache_req_src    (cache_req_src),
    .cache_resp_valid (cache_resp_valid)
  );

  initial begin
    ap_clk = 1'b0;
    forever #10 ap_clk = ~ap_clk;
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------

  // LCG returning its upper bits only
  function automatic int unsigned next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return {17'd0, seed[30:16]};
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_req(input string name, input cache_req_t got, input cache_req_t exp);
    if (got !== exp) begin
      abort_run($sformatf("error %s got %h expected %h", name, got, exp));
    end
  endtask

  // Outstanding count against its ceiling
  task automatic check_credits(input logic [credit_width-1:0] got,
                               input logic [credit_width-1:0] limit);
    if (got > limit) begin
      abort_run($sformatf("error outstanding got %h limit %h", got, limit));
    end
  endtask

  task automatic load_testdata();
    int fd;
    int n;
    string line;
    logic [7:0] src_ch;
    logic [addr_width-1:0] base;
    logic [addr_width-1:0] offset;
    logic [addr_width-1:0] addr;
    fd = $fopen("dv/cache_req_testdata.txt", "r");
    if (fd == 0) abort_run("cannot open dv/cache_req_testdata.txt");
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      // Skip blank and comment lines
      if (n > 1 && line[0] != "#") begin
        n = $sscanf(line, "%c %h %h %h", src_ch, base, offset, addr);
        if (n != 4) abort_run({"malformed testdata line: ", line});
        if (addr !== base + offset) begin
          abort_run($sformatf("error expected_addr got %h expected %h", addr, base + offset));
        end
        if (src_ch == "a") begin
          a_base_q.push_back(base);
          a_off_q.push_back(offset);
          a_addr_q.push_back(addr);
        end else if (src_ch == "b") begin
          b_base_q.push_back(base);
          b_off_q.push_back(offset);
          b_addr_q.push_back(addr);
        end else begin
          abort_run({"unknown source in testdata line: ", line});
        end
      end
    end
    $fclose(fd);
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial begin : main
    int total;
    int issued;
    int in_flight;
    int resp_wait;
    int quiet;
    int cycle;
    int extra;
    logic withhold;
    logic stall_prev;
    logic have_last;
    logic last_src;
    cache_req_t held;
    cache_req_t cur;
    cache_req_t t;

    control_areset   = 1'b1;
    req_a_valid      = 1'b0;
    req_a_base       = '0;
    req_a_offset     = '0;
    req_b_valid      = 1'b0;
    req_b_base       = '0;
    req_b_offset     = '0;
    cache_req_ready  = 1'b0;
    cache_resp_valid = 1'b0;
    seed             = 32'd7795;
    load_testdata();
    total      = a_base_q.size() + b_base_q.size();
    issued     = 0;
    in_flight  = 0;
    resp_wait  = 0;
    quiet      = 0;
    cycle      = 0;
    extra      = 0;
    // Responses held back until the credits run dry
    withhold   = 1'b1;
    stall_prev = 1'b0;
    have_last  = 1'b0;
    last_src   = 1'b0;
    held       = '0;

    repeat (5) @(posedge ap_clk);
    @(negedge ap_clk);
    control_areset = 1'b0;
    if (cache_req_valid !== 1'b0) abort_run("cache_req_valid is high right after reset");

    while (issued < total) begin
      cycle++;
      if (cycle > 3000) abort_run("timeout: requests did not all reach the cache in 3000 cycles");

      // Each requestor offers its head entry until it is taken
      req_a_valid  = (a_base_q.size() != 0);
      req_a_base   = req_a_valid ? a_base_q[0] : '0;
      req_a_offset = req_a_valid ? a_off_q[0] : '0;
      req_b_valid  = (b_base_q.size() != 0);
      req_b_base   = req_b_valid ? b_base_q[0] : '0;
      req_b_offset = req_b_valid ? b_off_q[0] : '0;
      cache_req_ready = withhold | ((next_rand() % 4) != 0);

      // One response pulse at a time with a random gap
      cache_resp_valid = 1'b0;
      if (!withhold && in_flight != 0) begin
        if (resp_wait == 0) begin
          cache_resp_valid = 1'b1;
          in_flight--;
          resp_wait = next_rand() % 6;
        end else begin
          resp_wait--;
        end
      end

      // Mid low phase so everything settles before the rising edge
      #5;
      if (req_a_valid && req_a_ready) begin
        if (req_b_valid && have_last && !last_src) abort_run("requestor a won twice in a row");
        t.addr = a_addr_q.pop_front();
        t.src  = 1'b0;
        exp_a.push_back(t);
        void'(a_base_q.pop_front());
        void'(a_off_q.pop_front());
        have_last = 1'b1;
        last_src  = 1'b0;
      end
      if (req_b_valid && req_b_ready) begin
        if (req_a_valid && have_last && last_src) abort_run("requestor b won twice in a row");
        t.addr = b_addr_q.pop_front();
        t.src  = 1'b1;
        exp_b.push_back(t);
        void'(b_base_q.pop_front());
        void'(b_off_q.pop_front());
        have_last = 1'b1;
        last_src  = 1'b1;
      end

      cur.addr = cache_req_addr;
      cur.src  = cache_req_src;
      // Stalled request must not move
      if (stall_prev) begin
        if (cache_req_valid !== 1'b1) begin
          abort_run($sformatf("error cache_req_valid got %h expected %h", cache_req_valid, 1'b1));
        end
        check_req("cache_req_held", cur, held);
      end
      stall_prev = cache_req_valid & ~cache_req_ready;
      held       = cur;

      if (cache_req_valid && cache_req_ready) begin
        if (!cur.src) begin
          if (exp_a.size() == 0) abort_run("request from a issued that was never accepted");
          check_req("cache_req_a", cur, exp_a.pop_front());
        end else begin
          if (exp_b.size() == 0) abort_run("request from b issued that was never accepted");
          check_req("cache_req_b", cur, exp_b.pop_front());
        end
        issued++;
        in_flight++;
        check_credits(credit_width'(in_flight), credit_width'(outstanding_max));
      end

      // Credits spent so nothing issues for 50 cycles and the full FIFO stalls the requestors
      if (withhold && issued == outstanding_max) begin
        quiet++;
        if (quiet == 51) begin
          if (req_a_ready || req_b_ready) abort_run("requestor ready still high with FIFO full");
          withhold = 1'b0;
        end
      end
      @(negedge ap_clk);
    end

    // Nothing more may reach the cache once every request is out
    req_a_valid     = 1'b0;
    req_b_valid     = 1'b0;
    cache_req_ready = 1'b1;
    repeat (50) begin
      // Hand back every credit still held by the cache
      cache_resp_valid = (in_flight != 0);
      if (in_flight != 0) in_flight--;
      #5;
      if (cache_req_valid === 1'b1) extra++;
      @(negedge ap_clk);
    end
    cache_resp_valid = 1'b0;

    if (extra != 0) begin
      abort_run($sformatf("%0d requests issued after the last expected one", extra));
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

// File: dv/cache_req_testdata.txt
# columns: source (a or b), base, offset, expected line address, all hex
# expected address is base plus offset modulo 2^32
a 00001000 00000040 00001040
b 00020000 00000100 00020100
a 00001000 00000080 00001080
b 00020000 00000180 00020180
a 00001000 000000c0 000010c0
b 0003f000 00000fc0 0003ffc0
a 10000000 00000000 10000000
b 00020000 00001000 00021000
a 7fffffc0 00000040 80000000
b ffffff00 00000200 00000100
a 00400000 00012340 00412340
b 00500000 00000040 00500040
a 0000abc0 00005440 00010000
b 12345600 00000080 12345680
a deadbe00 00000100 deadbf00
b 00500000 00000080 00500080
a 00001000 00000100 00001100
b 0fffffc0 00000040 10000000
a 00001000 00000140 00001140
b 00020000 00000200 00020200
a cafe0000 0000ff40 cafeff40
b 00600040 00000000 00600040
a 00001000 00000180 00001180
b 80000000 80000000 00000000

// File: verilog.f
hdl/cache_req_pkg.sv
hdl/cache_req_if.sv
hdl/request_arbiter.sv
hdl/cache_req_fifo.sv
hdl/cache_req_issuer.sv
hdl/cache_request_frontend.sv
dv/cache_request_frontend_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f verilog.f --top-module cache_request_frontend_tb -o sim_tb
./obj_dir/sim_tb
